//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/core_assert.sv
`timescale 1ns/10ps
`default_nettype none

module core_assert import riscv_pkg::*; (
  input logic                  clk,
  input logic                  reset,
  input logic                  result_valid,
  input logic                  load_en,
  input logic                  de_valid,
  input logic [REG_AWIDTH-1:0] de_rs1,
  input logic [REG_AWIDTH-1:0] de_rs2,
  input logic [XLEN-1:0]       op_a,
  input logic [XLEN-1:0]       op_b
);

  // Strobe stays low once reset has been held a cycle
  valid_low_in_reset: assert property (
    @(posedge clk) (reset && $past(reset)) |-> !result_valid
  ) else $error("result_valid high while reset is held");

  // Execute operands after forwarding, x0 must stay zero even when x0 is written
  x0_op_a_zero: assert property (@(posedge clk) (de_valid && de_rs1 == '0) |-> (op_a == '0))
    else $error("x0 operand a nonzero in execute");

  x0_op_b_zero: assert property (@(posedge clk) (de_valid && de_rs2 == '0) |-> (op_b == '0))
    else $error("x0 operand b nonzero in execute");

  load_in_reset: assert property (@(posedge clk) load_en |-> reset)
    else $error("load port write outside reset");

endmodule

bind core_top core_assert i_core_assert (
  .clk          (clk),
  .reset        (reset),
  .result_valid (result_valid),
  .load_en      (load_en),
  .de_valid     (de_valid),
  .de_rs1       (de_rs1),
  .de_rs2       (de_rs2),
  .op_a         (op_a),
  .op_b         (op_b_reg)
);

`default_nettype wire

//--- dv/core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module core_tb;

  localparam int          MEM_AWIDTH = 12;
  localparam int          CLK_PERIOD = 4;
  localparam int          MAX_ROWS   = 32;
  localparam int          ROW_WORDS  = 16;
  localparam logic [31:0] HALT       = 32'h0000006f;  // jal x0, 0

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  load_en;
  logic [MEM_AWIDTH-1:0] load_addr;
  logic [31:0]           load_data;
  logic [31:0]           result;
  logic                  result_valid;

  // Program table, one row per test
  string       row_name [MAX_ROWS];
  logic [31:0] row_prog [MAX_ROWS][ROW_WORDS];
  logic [31:0] row_expect [MAX_ROWS];
  int          n_rows = 0;
  bit          table_ready = 1'b0;

  logic [31:0] prog [$];             // Row under construction
  logic [15:0] lfsr_state = 16'd12;
  int          n_pass = 0;
  int          n_fail = 0;
  int          cur_row = 0;

  core_top #(.MEM_AWIDTH(MEM_AWIDTH), .RESET_PC(32'h0)) i_dut (
    .clk          (clk),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .result       (result),
    .result_valid (result_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // RV32I instruction encodings
  function automatic logic [31:0] rtype(input int f3, input int alt, input int rd,
                                        input int rs1, input int rs2);
    return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] itype(input int f3, input int rd, input int rs1,
                                        input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] lui(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(input int ne, input int rs1, input int rs2,
                                         input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], 2'b00, ne[0], off[4:1], off[11],
            7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  // Reference result by funct3, alt picks SUB or SRA
  function automatic logic [31:0] alu_expect(input int f3, input int alt,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      0:       return (alt != 0) ? a - b : a + b;
      1:       return a << b[4:0];
      2:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3:       return (a < b) ? 32'd1 : 32'd0;
      4:       return a ^ b;
      5:       return (alt != 0) ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      6:       return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic push_word(input logic [31:0] w);
    prog.push_back(w);
  endtask

  task automatic load_const(input int rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;  // Upper half absorbs the ADDI sign
    push_word(lui(rd, hi >> 12));
    push_word(itype(0, rd, rd, v));
  endtask

  // Store rs to the result register through x31
  task automatic report_reg(input int rs);
    push_word(lui(31, 'h80000));
    push_word(sw(rs, 31, 0));
  endtask

  task automatic add_row(input string name, input logic [31:0] expected);
    for (int i = 0; i < ROW_WORDS; i++) begin
      if (i < prog.size()) begin
        row_prog[n_rows][i] = prog[i];
      end else begin
        row_prog[n_rows][i] = HALT;  // Park the core after the program
      end
    end
    row_name[n_rows]   = name;
    row_expect[n_rows] = expected;
    n_rows++;
    prog.delete();
  endtask

  task automatic build_table();
    int          f3s [10]   = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    int          alts [10]  = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
    string       names [10] = '{"add", "sub", "sll", "slt", "sltu", "xor", "srl", "sra",
                                "or", "and"};
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    for (int k = 0; k < 10; k++) begin
      draw_bits(32, a);
      draw_bits(32, b);
      a[31] = 1'b1;  // Negative rs1 so SRA fills and SLT differs from SLTU
      b[31] = 1'b0;
      load_const(1, a);
      load_const(2, b);
      push_word(rtype(f3s[k], alts[k], 3, 1, 2));
      report_reg(3);
      add_row(names[k], alu_expect(f3s[k], alts[k], a, b));
      if (k != 1) begin  // No immediate form of SUB
        draw_bits(12, imm);
        if (f3s[k] == 1 || f3s[k] == 5) begin
          imm = (alts[k] != 0) ? {20'b0, 7'h20, imm[4:0]} : {27'b0, imm[4:0]};
        end else begin
          imm = {{20{imm[11]}}, imm[11:0]};
        end
        load_const(1, a);
        push_word(itype(f3s[k], 4, 1, imm));
        report_reg(4);
        add_row($sformatf("%s imm", names[k]), alu_expect(f3s[k], alts[k], a, imm));
      end
    end

    // Distance 1 from writeback, distance 2 through the bypass
    push_word(itype(0, 1, 0, 5));
    push_word(itype(0, 2, 1, 7));
    push_word(rtype(0, 0, 3, 2, 1));
    push_word(rtype(0, 0, 4, 3, 2));
    report_reg(4);
    add_row("forward and bypass", 32'd29);

    push_word(itype(0, 1, 0, 'h100));
    load_const(2, 32'hcafe1234);
    push_word(sw(2, 1, 0));
    push_word(lw(3, 1, 0));
    push_word(rtype(0, 0, 4, 3, 2));  // Uses the load right away
    report_reg(4);
    add_row("sw then lw", 32'h95fc2468);

    push_word(itype(0, 1, 0, 3));
    push_word(itype(0, 2, 0, 3));
    push_word(branch(0, 1, 2, 12));
    push_word(itype(0, 5, 0, 1));
    push_word(itype(0, 5, 0, 2));
    push_word(itype(0, 6, 5, 9));
    report_reg(6);
    add_row("beq taken", 32'd9);

    // The skipped store would report 1 first
    push_word(lui(31, 'h80000));
    push_word(itype(0, 1, 0, 3));
    push_word(itype(0, 2, 0, 4));
    push_word(branch(1, 1, 2, 12));
    push_word(itype(0, 5, 0, 1));
    push_word(sw(5, 31, 0));
    push_word(itype(0, 6, 5, 20));
    push_word(sw(6, 31, 0));
    add_row("bne taken", 32'd20);

    push_word(itype(0, 1, 0, 3));
    push_word(itype(0, 2, 0, 3));
    push_word(branch(1, 1, 2, 12));
    push_word(itype(0, 5, 0, 1));
    push_word(itype(0, 5, 5, 2));
    push_word(itype(0, 6, 5, 9));
    report_reg(6);
    add_row("bne not taken", 32'd12);

    push_word(itype(0, 5, 0, 100));
    push_word(jal(1, 12));            // Link is 8
    push_word(itype(0, 5, 0, 7));
    push_word(itype(0, 5, 0, 8));
    push_word(rtype(0, 0, 6, 1, 5));
    report_reg(6);
    add_row("jal link", 32'd108);

    push_word(lui(31, 'h80000));
    push_word(itype(0, 0, 0, 55));
    push_word(sw(0, 31, 0));
    add_row("x0 stays zero", 32'd0);

    load_const(7, 32'hdeadbeef);
    report_reg(7);
    add_row("lui addi", 32'hdeadbeef);
  endtask

  // Load under reset, release, wait for the result strobe
  task automatic run_row(input int r);
    @(posedge clk);
    #1;
    reset = 1'b1;
    for (int i = 0; i < ROW_WORDS; i++) begin
      load_en   = 1'b1;
      load_addr = MEM_AWIDTH'(i);
      load_data = row_prog[r][i];
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    do begin
      @(negedge clk);
    end while (!result_valid);
    assert (result === row_expect[r]) begin
      n_pass++;
      $display("PASS %s: result %08h", row_name[r], result);
    end else begin
      n_fail++;
      $display("ERR result expected %08h actual %08h in %s", row_expect[r], result,
               row_name[r]);
    end
  endtask

  initial begin
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    build_table();
    table_ready = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      cur_row = r;
      run_row(r);
    end
    $display("Summary: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Each row gets 16 instructions plus 40 cycles
  initial begin
    wait (table_ready);
    #(n_rows * (ROW_WORDS + 40) * CLK_PERIOD);
    n_fail++;
    $display("Timeout in %s: no result appeared", row_name[cur_row]);
    $display("Summary: %0d passed, %0d failed", n_pass, n_fail);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import riscv_pkg::*; (
  input  alu_op_e         op,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  output logic [XLEN-1:0] y,
  output logic            equal
);

  logic [SHAMT_WIDTH-1:0] shamt;

  assign shamt = b[SHAMT_WIDTH-1:0];
  assign equal = (a == b);  // BEQ and BNE compare rs1 against rs2

  always_comb begin
    case (op)
      ADD:     y = a + b;
      SUB:     y = a - b;
      AND:     y = a & b;
      OR:      y = a | b;
      XOR:     y = a ^ b;
      SLT:     y = XLEN'($signed(a) < $signed(b));
      SLTU:    y = XLEN'(a < b);
      SLL:     y = a << shamt;
      SRL:     y = a >> shamt;
      SRA:     y = $unsigned($signed(a) >>> shamt);  // Sign fill
      PASS_B:  y = b;
      default: y = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top import riscv_pkg::*; #(
  parameter int              MEM_AWIDTH = 12,
  parameter logic [XLEN-1:0] RESET_PC   = '0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load_en,
  input  logic [MEM_AWIDTH-1:0] load_addr,
  input  logic [XLEN-1:0]       load_data,
  output logic [XLEN-1:0]       result,
  output logic                  result_valid
);

  logic                  redirect;
  logic [XLEN-1:0]       target, pc;
  logic [MEM_AWIDTH-1:0] ram_addr0, ram_addr1;
  logic [3:0]            ram_wbe0, ram_wbe1;
  logic [XLEN-1:0]       ram_q0, ram_q1;

  logic            fd_valid;
  logic [XLEN-1:0] fd_pc;

  alu_op_e         dec_alu_op;
  wb_sel_e         dec_wb_sel;
  logic [XLEN-1:0] dec_imm, rs1_data, rs2_data;
  logic            dec_use_imm, dec_reg_we, dec_mem_we, dec_is_branch;
  logic            dec_branch_ne, dec_is_jump, dec_illegal;

  logic                  de_valid, de_reg_we, de_mem_we, de_is_branch, de_is_jump;
  logic                  de_use_imm, de_branch_ne;
  alu_op_e               de_alu_op;
  wb_sel_e               de_wb_sel;
  logic [XLEN-1:0]       de_pc, de_imm, de_rs1_data, de_rs2_data;
  logic [REG_AWIDTH-1:0] de_rs1, de_rs2, de_rd;

  logic [XLEN-1:0] op_a, op_b_reg, alu_b, alu_y;
  logic            alu_equal, ex_store, ex_result_store;

  logic                  ew_reg_we;
  logic [REG_AWIDTH-1:0] ew_rd;
  wb_sel_e               ew_wb_sel;
  logic [XLEN-1:0]       ew_alu_y, ew_pc4, wb_data;

  program_counter #(.RESET_PC(RESET_PC)) u_pc (
    .clk      (clk),
    .reset    (reset),
    .redirect (redirect),
    .target   (target),
    .pc       (pc)
  );

  // Port 0 takes load writes during reset, fetch otherwise
  assign ram_addr0 = load_en ? load_addr : pc[MEM_AWIDTH+1:2];
  assign ram_wbe0  = {4{load_en}};

  sync_ram_dp #(.MEM_AWIDTH(MEM_AWIDTH)) u_ram (
    .clk   (clk),
    .addr0 (ram_addr0),
    .addr1 (ram_addr1),
    .wbe0  (ram_wbe0),
    .wbe1  (ram_wbe1),
    .d0    (load_data),
    .d1    (op_b_reg),
    .q0    (ram_q0),
    .q1    (ram_q1)
  );

  // Decode works straight on the RAM output word
  instr_decoder u_dec (
    .instr     (ram_q0),
    .alu_op    (dec_alu_op),
    .imm       (dec_imm),
    .use_imm   (dec_use_imm),
    .reg_we    (dec_reg_we),
    .mem_we    (dec_mem_we),
    .wb_sel    (dec_wb_sel),
    .is_branch (dec_is_branch),
    .branch_ne (dec_branch_ne),
    .is_jump   (dec_is_jump),
    .illegal   (dec_illegal)
  );

  reg_file u_rf (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (ram_q0[19:15]),
    .rs2_addr (ram_q0[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (ew_reg_we),
    .rd_addr  (ew_rd),
    .rd_data  (wb_data)
  );

  // Forward from writeback, the instruction just ahead
  assign op_a     = (ew_reg_we && ew_rd != '0 && ew_rd == de_rs1) ? wb_data : de_rs1_data;
  assign op_b_reg = (ew_reg_we && ew_rd != '0 && ew_rd == de_rs2) ? wb_data : de_rs2_data;
  assign alu_b    = de_use_imm ? de_imm : op_b_reg;

  alu u_alu (
    .op    (de_alu_op),
    .a     (op_a),
    .b     (alu_b),
    .y     (alu_y),
    .equal (alu_equal)
  );

  assign redirect = de_valid && (de_is_jump || (de_is_branch && (alu_equal ^ de_branch_ne)));
  assign target   = de_pc + de_imm;

  // Bit 31 of the store address maps to the result register
  assign ex_store        = de_valid && de_mem_we;
  assign ex_result_store = ex_store && alu_y[XLEN-1];
  assign ram_addr1       = alu_y[MEM_AWIDTH+1:2];
  assign ram_wbe1        = {4{ex_store && !alu_y[XLEN-1]}};

  always_comb begin
    case (ew_wb_sel)
      MEM:      wb_data = ram_q1;  // LW read issued from execute
      PC_PLUS4: wb_data = ew_pc4;
      default:  wb_data = ew_alu_y;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fd_valid     <= 1'b0;
      de_valid     <= 1'b0;
      de_reg_we    <= 1'b0;
      de_mem_we    <= 1'b0;
      de_is_branch <= 1'b0;
      de_is_jump   <= 1'b0;
      ew_reg_we    <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      fd_valid     <= !redirect;  // Squash the word in flight
      de_valid     <= fd_valid && !dec_illegal && !redirect;
      de_reg_we    <= dec_reg_we;
      de_mem_we    <= dec_mem_we;
      de_is_branch <= dec_is_branch;
      de_is_jump   <= dec_is_jump;
      ew_reg_we    <= de_valid && de_reg_we;
      result_valid <= ex_result_store;
    end
  end

  always_ff @(posedge clk) begin
    fd_pc        <= pc;
    de_pc        <= fd_pc;
    de_imm       <= dec_imm;
    de_alu_op    <= dec_alu_op;
    de_use_imm   <= dec_use_imm;
    de_branch_ne <= dec_branch_ne;
    de_wb_sel    <= dec_wb_sel;
    de_rs1_data  <= rs1_data;
    de_rs2_data  <= rs2_data;
    de_rs1       <= ram_q0[19:15];
    de_rs2       <= ram_q0[24:20];
    de_rd        <= ram_q0[11:7];
    ew_rd        <= de_rd;
    ew_wb_sel    <= de_wb_sel;
    ew_alu_y     <= alu_y;
    ew_pc4       <= de_pc + XLEN'(4);
    if (ex_result_store) begin
      result <= op_b_reg;
    end
  end

endmodule

`default_nettype wire

//--- logic/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder import riscv_pkg::*; (
  input  logic [XLEN-1:0] instr,
  output alu_op_e         alu_op,
  output logic [XLEN-1:0] imm,
  output logic            use_imm,
  output logic            reg_we,
  output logic            mem_we,
  output wb_sel_e         wb_sel,
  output logic            is_branch,
  output logic            branch_ne,
  output logic            is_jump,
  output logic            illegal
);

  opcode_e                 opcode;
  logic [FUNCT3_WIDTH-1:0] funct3;
  logic [FUNCT7_WIDTH-1:0] funct7;
  logic [XLEN-1:0]         imm_i, imm_s, imm_b, imm_u, imm_j;

  // Shared by OP and OP_IMM, alt selects SUB or SRA
  function automatic alu_op_e funct_to_op(input logic [FUNCT3_WIDTH-1:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return alt ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  assign opcode = opcode_e'(instr[OPCODE_WIDTH-1:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    alu_op    = ADD;
    imm       = imm_i;
    use_imm   = 1'b0;
    reg_we    = 1'b0;
    mem_we    = 1'b0;
    wb_sel    = ALU;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    is_jump   = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      OP: begin
        alu_op = funct_to_op(funct3, funct7[5]);
        reg_we = 1'b1;
      end
      OP_IMM: begin
        // Only the shift-right form looks at bit 30
        alu_op  = funct_to_op(funct3, (funct3 == 3'b101) && funct7[5]);
        use_imm = 1'b1;
        reg_we  = 1'b1;
      end
      LUI: begin
        alu_op  = PASS_B;
        imm     = imm_u;
        use_imm = 1'b1;
        reg_we  = 1'b1;
      end
      LOAD: begin
        use_imm = 1'b1;
        reg_we  = 1'b1;
        wb_sel  = MEM;
        illegal = (funct3 != 3'b010);  // Word loads only
      end
      STORE: begin
        imm     = imm_s;
        use_imm = 1'b1;
        mem_we  = 1'b1;
        illegal = (funct3 != 3'b010);
      end
      BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
        branch_ne = funct3[0];             // BNE
        illegal   = (funct3[2:1] != 2'b00);  // BEQ and BNE only
      end
      JAL: begin
        imm     = imm_j;
        reg_we  = 1'b1;
        wb_sel  = PC_PLUS4;
        is_jump = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/program_counter.sv
`timescale 1ns/10ps
`default_nettype none

module program_counter import riscv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            redirect,
  input  logic [XLEN-1:0] target,
  output logic [XLEN-1:0] pc
);

  // Taken branch or jump from execute wins over sequential fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (redirect) begin
      pc <= target;
    end else begin
      pc <= pc + XLEN'(4);
    end
  end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import riscv_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [REG_AWIDTH-1:0] rs1_addr,
  input  logic [REG_AWIDTH-1:0] rs2_addr,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data,
  input  logic                  we,
  input  logic [REG_AWIDTH-1:0] rd_addr,
  input  logic [XLEN-1:0]       rd_data
);

  logic [XLEN-1:0] regs [1:2**REG_AWIDTH-1];  // No storage for x0

  // Write-through, a read of the index being written sees the new value
  function automatic logic [XLEN-1:0] read_port(input logic [REG_AWIDTH-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (we && addr == rd_addr) begin
      return rd_data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 2**REG_AWIDTH; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  always_comb rs1_data = read_port(rs1_addr);
  always_comb rs2_data = read_port(rs2_addr);

endmodule

`default_nettype wire

//--- logic/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  parameter int XLEN         = 32;
  parameter int REG_AWIDTH   = 5;
  parameter int OPCODE_WIDTH = 7;
  parameter int FUNCT3_WIDTH = 3;
  parameter int FUNCT7_WIDTH = 7;
  parameter int SHAMT_WIDTH  = 5;  // Shift amount, low bits of operand b

  // RV32I major opcodes handled by the core
  typedef enum logic [OPCODE_WIDTH-1:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    AND    = 4'd2,
    OR     = 4'd3,
    XOR    = 4'd4,
    SLT    = 4'd5,
    SLTU   = 4'd6,
    SLL    = 4'd7,
    SRL    = 4'd8,
    SRA    = 4'd9,
    PASS_B = 4'd10  // LUI, immediate straight through
  } alu_op_e;

  // Writeback source
  typedef enum logic [1:0] {
    ALU      = 2'd0,
    MEM      = 2'd1,
    PC_PLUS4 = 2'd2
  } wb_sel_e;

endpackage

`default_nettype wire

//--- logic/sync_ram_dp.sv
`timescale 1ns/10ps
`default_nettype none

module sync_ram_dp import riscv_pkg::*; #(
  parameter int MEM_AWIDTH = 12
) (
  input  logic                  clk,
  input  logic [MEM_AWIDTH-1:0] addr0,
  input  logic [MEM_AWIDTH-1:0] addr1,
  input  logic [3:0]            wbe0,
  input  logic [3:0]            wbe1,
  input  logic [XLEN-1:0]       d0,
  input  logic [XLEN-1:0]       d1,
  output logic [XLEN-1:0]       q0,
  output logic [XLEN-1:0]       q1
);

  logic [XLEN-1:0] mem [2**MEM_AWIDTH];

  // Both ports in one process, port 1 wins a same-byte collision
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wbe0[i]) begin
        mem[addr0][8*i +: 8] <= d0[8*i +: 8];
      end
      if (wbe1[i]) begin
        mem[addr1][8*i +: 8] <= d1[8*i +: 8];
      end
    end
    q0 <= mem[addr0];  // Old data on a same-cycle write
    q1 <= mem[addr1];
  end

endmodule

`default_nettype wire

//--- sources.f
logic/riscv_pkg.sv
logic/program_counter.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/sync_ram_dp.sv
logic/core_top.sv
dv/core_assert.sv
dv/core_tb.sv
